// ==== src/fpu_macros.svh ====
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// ===========================================================================
// Widths and constants for the single-cycle FPU
// ===========================================================================

// Word widths
`define FLEN      32           // Single-precision word
`define XLEN      32           // Integer register word

// Control field widths
`define OP_W      5            // Operation code from decode

// Classify mask
`define CLASS_W   10           // One bit per IEEE category

// Canonical quiet NaN as produced by FMIN/FMAX when both inputs are NaN
`define CANON_NAN 32'h7FC00000

`endif

// ==== src/fpu_pkg.sv ====
`include "fpu_macros.svh"

package fpu_pkg;

  // ===========================================================================
  // Word types
  // ===========================================================================
  typedef logic [`FLEN-1:0] fp_word_t;     // Single-precision bit pattern
  typedef logic [`XLEN-1:0] int_word_t;    // Integer register value
  typedef logic [2:0]       cmp_funct3_t;  // Instruction funct3 (FEQ/FLT/FLE)

  // Operation codes, same encoding as the decode unit
  typedef enum logic [`OP_W-1:0] {
    FP_SGNJ  = 5'd5,
    FP_SGNJN = 5'd6,
    FP_SGNJX = 5'd7,
    FP_MIN   = 5'd8,
    FP_MAX   = 5'd9,
    FP_CMP   = 5'd11,           // funct3 picks FEQ/FLT/FLE
    FP_CLASS = 5'd12,
    FP_MV_XW = 5'd17,           // FP reg to int reg bitcast
    FP_MV_WX = 5'd18            // Int reg to FP reg bitcast
  } fpu_op_e;

  // FCLASS mask, first field is the MSB (bit 9)
  typedef struct packed {
    logic qnan;                 // Bit 9
    logic snan;                 // Bit 8
    logic pos_inf;
    logic pos_norm;
    logic pos_sub;
    logic pos_zero;
    logic neg_zero;
    logic neg_sub;
    logic neg_norm;
    logic neg_inf;              // Bit 0
  } fp_class_t;

  // ===========================================================================
  // Request, compare and response bundles
  // ===========================================================================
  typedef struct packed {
    fpu_op_e     op;
    cmp_funct3_t funct3;
    fp_word_t    operand_a;     // rs1
    fp_word_t    operand_b;     // rs2
    int_word_t   int_operand;   // Integer source for FMV.W.X
  } fpu_req_t;

  typedef struct packed {
    int_word_t cmp_word;        // 0 or 1
    fp_word_t  minmax_word;
    logic      cmp_nv;
    logic      minmax_nv;
  } cmp_out_t;

  typedef struct packed {
    fp_word_t  fp_result;
    int_word_t int_result;
    logic      flag_nv;         // Invalid operation
  } fpu_rsp_t;

endpackage

// ==== src/fp_classify.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_classify (
  input  fpu_pkg::fp_word_t  operand,   // Word to classify
  output fpu_pkg::fp_class_t cls        // Exactly one bit set
);

  // Field split
  logic        sign;
  logic [7:0]  exponent;
  logic [22:0] fraction;

  logic exp_ones;                       // Inf or NaN
  logic exp_zero;                       // Zero or subnormal
  logic frac_zero;

  assign sign     = operand[`FLEN-1];
  assign exponent = operand[`FLEN-2:23];
  assign fraction = operand[22:0];

  assign exp_ones  = &exponent;
  assign exp_zero  = ~|exponent;
  assign frac_zero = ~|fraction;

  always_comb begin
    cls = '0;
    if (exp_ones) begin
      if (frac_zero) begin
        // Infinity
        if (sign) begin
          cls.neg_inf = 1'b1;
        end else begin
          cls.pos_inf = 1'b1;
        end
      end else if (fraction[22]) begin
        cls.qnan = 1'b1;                // Quiet bit set
      end else begin
        cls.snan = 1'b1;                // Quiet bit clear, payload nonzero
      end
    end else if (exp_zero) begin
      if (frac_zero) begin
        if (sign) begin
          cls.neg_zero = 1'b1;
        end else begin
          cls.pos_zero = 1'b1;
        end
      end else begin
        // Denormal range
        if (sign) begin
          cls.neg_sub = 1'b1;
        end else begin
          cls.pos_sub = 1'b1;
        end
      end
    end else begin
      if (sign) begin
        cls.neg_norm = 1'b1;
      end else begin
        cls.pos_norm = 1'b1;
      end
    end
  end

endmodule

// ==== src/fp_compare.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_compare (
  input  fpu_pkg::fp_word_t    operand_a,
  input  fpu_pkg::fp_word_t    operand_b,
  input  fpu_pkg::fp_class_t   cls_a,       // From class_a_i
  input  fpu_pkg::fp_class_t   cls_b,       // From class_b_i
  input  fpu_pkg::fpu_op_e     op,          // Min or max select
  input  fpu_pkg::cmp_funct3_t funct3,      // FEQ/FLT/FLE select
  output fpu_pkg::cmp_out_t    cmp
);

  import fpu_pkg::*;

  // ===========================================================================
  // Shared sign-magnitude ordering
  // ===========================================================================
  logic              sign_a, sign_b;
  logic [`FLEN-2:0]  mag_a, mag_b;
  logic              mag_lt, mag_gt;
  logic              lt_raw;               // -0 below +0
  logic              eq_raw;               // Bitwise equal

  logic a_nan, b_nan, any_nan, any_snan;
  logic both_zero;

  assign sign_a = operand_a[`FLEN-1];
  assign sign_b = operand_b[`FLEN-1];
  assign mag_a  = operand_a[`FLEN-2:0];
  assign mag_b  = operand_b[`FLEN-2:0];
  assign mag_lt = mag_a < mag_b;
  assign mag_gt = mag_b < mag_a;
  assign eq_raw = operand_a == operand_b;

  always_comb begin
    if (sign_a != sign_b) begin
      lt_raw = sign_a;                     // Negative side is smaller
    end else if (sign_a) begin
      lt_raw = mag_gt;                     // Both negative, larger magnitude is smaller
    end else begin
      lt_raw = mag_lt;
    end
  end

  assign a_nan     = cls_a.snan | cls_a.qnan;
  assign b_nan     = cls_b.snan | cls_b.qnan;
  assign any_nan   = a_nan | b_nan;
  assign any_snan  = cls_a.snan | cls_b.snan;
  assign both_zero = (cls_a.pos_zero | cls_a.neg_zero) & (cls_b.pos_zero | cls_b.neg_zero);

  // ===========================================================================
  // FEQ / FLT / FLE
  // ===========================================================================
  logic cmp_lt, cmp_eq;                    // Zeros equal regardless of sign
  logic cmp_bit;
  logic cmp_nv;

  assign cmp_lt = lt_raw & ~both_zero;
  assign cmp_eq = eq_raw | both_zero;

  always_comb begin
    case (funct3)
      3'b001: begin                        // FLT
        cmp_bit = ~any_nan & cmp_lt;
        cmp_nv  = any_nan;                 // Signaling compare
      end
      3'b000: begin                        // FLE
        cmp_bit = ~any_nan & (cmp_lt | cmp_eq);
        cmp_nv  = any_nan;
      end
      default: begin                       // FEQ, also for unused codes
        cmp_bit = ~any_nan & cmp_eq;
        cmp_nv  = any_snan;                // Quiet compare
      end
    endcase
  end

  // ===========================================================================
  // FMIN / FMAX
  // ===========================================================================
  logic     is_max;
  fp_word_t minmax_word;

  assign is_max = op == FP_MAX;

  always_comb begin
    if (a_nan && b_nan) begin
      minmax_word = `CANON_NAN;
    end else if (a_nan) begin
      minmax_word = operand_b;             // NaN loses to a number
    end else if (b_nan) begin
      minmax_word = operand_a;
    end else if (is_max) begin
      minmax_word = lt_raw ? operand_b : operand_a;
    end else begin
      minmax_word = lt_raw ? operand_a : operand_b;
    end
  end

  assign cmp.cmp_word    = {{(`XLEN-1){1'b0}}, cmp_bit};
  assign cmp.minmax_word = minmax_word;
  assign cmp.cmp_nv      = cmp_nv;
  assign cmp.minmax_nv   = any_snan;       // Only sNaN is invalid here

endmodule

// ==== src/fpu_result_sel.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_result_sel (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,       // One-cycle request strobe
  input  fpu_pkg::fpu_req_t  req,
  input  fpu_pkg::fp_class_t cls_a,       // FCLASS source
  input  fpu_pkg::cmp_out_t  cmp,         // Compare and min/max results
  output logic               done,        // Pulse one clock after start
  output fpu_pkg::fpu_rsp_t  rsp
);

  import fpu_pkg::*;

  // ===========================================================================
  // Sign injection
  // ===========================================================================
  logic     inj_sign;
  fp_word_t sgnj_word;

  always_comb begin
    case (req.op)
      FP_SGNJN: inj_sign = ~req.operand_b[`FLEN-1];
      FP_SGNJX: inj_sign = req.operand_a[`FLEN-1] ^ req.operand_b[`FLEN-1];
      default:  inj_sign = req.operand_b[`FLEN-1];   // FSGNJ
    endcase
  end

  // Magnitude always from rs1, NaN payload untouched
  assign sgnj_word = {inj_sign, req.operand_a[`FLEN-2:0]};

  // ===========================================================================
  // Legality and result mux
  // ===========================================================================
  logic     op_legal;
  logic     fire;                               // Accepted request
  fpu_rsp_t rsp_d;

  always_comb begin
    case (req.op)
      FP_SGNJ, FP_SGNJN, FP_SGNJX,
      FP_MIN, FP_MAX,
      FP_CMP, FP_CLASS,
      FP_MV_XW, FP_MV_WX: op_legal = 1'b1;
      default:            op_legal = 1'b0;
    endcase
  end

  assign fire = start & op_legal;

  always_comb begin
    rsp_d = '0;                                 // Unused word stays zero
    case (req.op)
      FP_SGNJ, FP_SGNJN, FP_SGNJX: begin
        rsp_d.fp_result = sgnj_word;            // Never raises NV
      end
      FP_MIN, FP_MAX: begin
        rsp_d.fp_result = cmp.minmax_word;
        rsp_d.flag_nv   = cmp.minmax_nv;
      end
      FP_CMP: begin
        rsp_d.int_result = cmp.cmp_word;
        rsp_d.flag_nv    = cmp.cmp_nv;
      end
      FP_CLASS: begin
        // Mask zero-extended into rd
        rsp_d.int_result = {{(`XLEN-`CLASS_W){1'b0}}, cls_a};
      end
      FP_MV_XW: begin
        rsp_d.int_result = req.operand_a;       // Raw bits, no conversion
      end
      FP_MV_WX: begin
        rsp_d.fp_result = req.int_operand;
      end
      default: begin
        rsp_d = '0;
      end
    endcase
  end

  // ===========================================================================
  // Output registers
  // ===========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
      rsp  <= '0;
    end else begin
      done <= fire;                             // Illegal op gives no pulse
      if (fire) begin
        rsp <= rsp_d;                           // Held until next accepted op
      end
    end
  end

endmodule

// ==== src/fpu.sv ====
`timescale 1ns/1ps

module fpu (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,       // Request strobe, one per cycle max
  input  fpu_pkg::fpu_req_t req,
  output logic              done,        // Result valid pulse
  output fpu_pkg::fpu_rsp_t rsp
);

  import fpu_pkg::*;

  // Operand classes
  fp_class_t cls_a;
  fp_class_t cls_b;

  // Shared comparison results
  cmp_out_t  cmp;

  // ===========================================================================
  // Operand classification
  // ===========================================================================
  fp_classify class_a_i (
    .operand (req.operand_a),
    .cls     (cls_a)
  );

  fp_classify class_b_i (
    .operand (req.operand_b),
    .cls     (cls_b)
  );

  // ===========================================================================
  // Compare and min/max
  // ===========================================================================
  fp_compare cmp_i (
    .operand_a (req.operand_a),
    .operand_b (req.operand_b),
    .cls_a     (cls_a),
    .cls_b     (cls_b),
    .op        (req.op),
    .funct3    (req.funct3),
    .cmp       (cmp)
  );

  // ===========================================================================
  // Result stage
  // ===========================================================================
  // Single register stage, latency 1
  fpu_result_sel sel_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .req   (req),
    .cls_a (cls_a),           // FCLASS uses rs1 only
    .cmp   (cmp),
    .done  (done),
    .rsp   (rsp)
  );

endmodule

// ==== bench/fpu_chk.sv ====
`timescale 1ns/1ps

module fpu_chk (
  input logic              clk,
  input logic              rst_n,
  input logic              start,
  input fpu_pkg::fpu_req_t req,
  input logic              done,
  input fpu_pkg::fpu_rsp_t rsp
);

  import fpu_pkg::*;

  logic start_legal;                      // Accepted request this cycle
  logic quiet_op;                         // Ops that never raise NV

  assign start_legal = start && (req.op inside {FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_MIN, FP_MAX,
                                                FP_CMP, FP_CLASS, FP_MV_XW, FP_MV_WX});
  assign quiet_op    = req.op inside {FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_CLASS, FP_MV_XW, FP_MV_WX};

  // ==========================================================================
  // Protocol
  // ==========================================================================
  a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    start_legal |=> done)
    else $error("done missing one cycle after a legal start");

  a_no_stray_done: assert property (@(posedge clk) disable iff (!rst_n)
    !start_legal |=> !done)
    else $error("done without a legal start one cycle earlier");

  a_no_nv_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (start_legal && quiet_op) |=> !rsp.flag_nv)
    else $error("flag_nv raised by a sign-injection, classify or move op");

  // Outputs held at zero through reset
  a_reset_idle: assert property (@(posedge clk) !rst_n |=> (!done && rsp == '0))
    else $error("done or rsp not zero during reset");

endmodule

bind fpu fpu_chk chk_i (
  .clk   (clk),
  .rst_n (rst_n),
  .start (start),
  .req   (req),
  .done  (done),
  .rsp   (rsp)
);

// ==== bench/fpu_tb.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_tb;

  import fpu_pkg::*;

  localparam int TIMEOUT_CYCLES = 2600;   // 2000 random, ~150 directed, idles, margin

  logic     clk;
  logic     rst_n;
  logic     start;
  fpu_req_t req;
  logic     done;
  fpu_rsp_t rsp;

  fpu_rsp_t    exp_q[$];                  // Expected responses in issue order
  fpu_rsp_t    held_rsp;                  // Last checked response that rsp keeps between dones
  int unsigned n_checked;
  int unsigned cycle_cnt;

  // +0, -0, +inf, -inf, min subnormal, max normal, qNaN, sNaN
  fp_word_t specials[8] = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000,
                            32'h0000_0001, 32'h7F7F_FFFF, 32'h7FC0_0000, 32'h7FA0_0000};
  fpu_op_e  legal_ops[9] = '{FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_MIN, FP_MAX,
                             FP_CMP, FP_CLASS, FP_MV_XW, FP_MV_WX};
  cmp_funct3_t cmp_codes[3] = '{3'b010, 3'b001, 3'b000};   // FEQ, FLT, FLE

  fpu dut_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .req   (req),
    .done  (done),
    .rsp   (rsp)
  );

  always #5 clk = ~clk;                   // 10 ns period

  // ==========================================================================
  // Failure reporting and typed compares
  // ==========================================================================
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_fp(input fp_word_t got, input fp_word_t exp);
    if (got !== exp)
      fail_run($sformatf("ERROR @ %0t: result %0d fp_result %h, expected %h",
                         $time, n_checked, got, exp));
  endtask

  task automatic check_int(input int_word_t got, input int_word_t exp);
    if (got !== exp)
      fail_run($sformatf("ERROR @ %0t: result %0d int_result %h, expected %h",
                         $time, n_checked, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("ERROR @ %0t: result %0d flag_nv %b, expected %b",
                         $time, n_checked, got, exp));
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================
  function automatic logic is_legal_op(input logic [`OP_W-1:0] code);
    return code inside {5, 6, 7, 8, 9, 11, 12, 17, 18};
  endfunction

  // One-hot mask from index 0 for -inf up to 9 for qNaN
  function automatic fp_class_t ref_class(input fp_word_t w);
    int idx;
    if (w[30:23] == 8'hFF && w[22:0] != 0) idx = w[22] ? 9 : 8;
    else if (w[30:23] == 8'hFF)            idx = w[31] ? 0 : 7;
    else if (w[30:0] == 0)                 idx = w[31] ? 3 : 4;
    else if (w[30:23] == 8'h00)            idx = w[31] ? 2 : 5;
    else                                   idx = w[31] ? 1 : 6;
    return fp_class_t'(10'd1 << idx);
  endfunction

  // Signed ordering key that maps both zeros to 0
  function automatic longint order_key(input fp_word_t w);
    return w[31] ? -longint'(w[30:0]) : longint'(w[30:0]);
  endfunction

  function automatic fpu_rsp_t ref_fpu(input fpu_req_t r);
    fpu_rsp_t  e;
    fp_class_t ca, cb;
    logic      a_nan, b_nan, any_snan, a_below_b, hit;
    longint    ka, kb;
    e        = '0;
    ca       = ref_class(r.operand_a);
    cb       = ref_class(r.operand_b);
    a_nan    = ca.snan | ca.qnan;
    b_nan    = cb.snan | cb.qnan;
    any_snan = ca.snan | cb.snan;
    ka       = order_key(r.operand_a);
    kb       = order_key(r.operand_b);
    // Total order for min/max puts -0 below +0
    a_below_b = (ka < kb) || (ka == kb && r.operand_a[31] && !r.operand_b[31]);
    case (r.op)
      FP_SGNJ:  e.fp_result = {r.operand_b[31], r.operand_a[30:0]};
      FP_SGNJN: e.fp_result = {~r.operand_b[31], r.operand_a[30:0]};
      FP_SGNJX: e.fp_result = {r.operand_a[31] ^ r.operand_b[31], r.operand_a[30:0]};
      FP_MIN, FP_MAX: begin
        if (a_nan && b_nan)     e.fp_result = `CANON_NAN;
        else if (a_nan)         e.fp_result = r.operand_b;
        else if (b_nan)         e.fp_result = r.operand_a;
        else if (r.op == FP_MIN) e.fp_result = a_below_b ? r.operand_a : r.operand_b;
        else                    e.fp_result = a_below_b ? r.operand_b : r.operand_a;
        e.flag_nv = any_snan;
      end
      FP_CMP: begin
        case (r.funct3)
          3'b001: begin                   // FLT
            hit       = ka < kb;
            e.flag_nv = a_nan | b_nan;
          end
          3'b000: begin                   // FLE
            hit       = ka <= kb;
            e.flag_nv = a_nan | b_nan;
          end
          default: begin                  // FEQ
            hit       = ka == kb;
            e.flag_nv = any_snan;
          end
        endcase
        e.int_result[0] = hit & ~a_nan & ~b_nan;
      end
      FP_CLASS: e.int_result[9:0] = ca;
      FP_MV_XW: e.int_result = r.operand_a;
      FP_MV_WX: e.fp_result = r.int_operand;
      default:  e = '0;
    endcase
    return e;
  endfunction

  // ==========================================================================
  // Stimulus helpers
  // ==========================================================================
  function automatic fp_word_t rand_operand();
    case ($urandom % 5)
      0:       return specials[$urandom % 8];
      1:       return {1'($urandom), 8'hFF, 23'($urandom)};   // Inf and NaN range
      2:       return {1'($urandom), 8'h00, 23'($urandom)};   // Zero and subnormal
      default: return $urandom;
    endcase
  endfunction

  function automatic fpu_req_t random_req();
    fpu_req_t r;
    r.op          = legal_ops[$urandom % 9];
    r.funct3      = 3'($urandom);                 // Unused codes too
    r.operand_a   = rand_operand();
    r.operand_b   = rand_operand();
    r.int_operand = $urandom;
    if ($urandom % 8 == 0) r.operand_b = r.operand_a ^ {1'($urandom), 31'd0};  // Ties
    return r;
  endfunction

  function automatic logic [`OP_W-1:0] illegal_code();
    logic [`OP_W-1:0] code;
    do code = 5'($urandom); while (is_legal_op(code));
    return code;
  endfunction

  // Drive on the falling edge and queue the expected response
  task automatic drive_req(input fpu_req_t r, input logic s);
    @(negedge clk);
    start = s;
    req   = r;
    if (s && is_legal_op(r.op)) exp_q.push_back(ref_fpu(r));
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    start = 1'b0;
  endtask

  // ==========================================================================
  // Scoreboard and timeout
  // ==========================================================================
  always @(negedge clk) begin
    fpu_rsp_t exp_rsp;
    if (rst_n && done) begin
      if (exp_q.size() == 0) begin
        fail_run("done pulse seen with no request outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        check_fp(rsp.fp_result, exp_rsp.fp_result);
        check_int(rsp.int_result, exp_rsp.int_result);
        check_flag(rsp.flag_nv, exp_rsp.flag_nv);
        held_rsp = exp_rsp;
        n_checked++;
      end
    end else if (rst_n) begin
      // Idle or illegal op leaves rsp on the last result
      check_fp(rsp.fp_result, held_rsp.fp_result);
      check_int(rsp.int_result, held_rsp.int_result);
      check_flag(rsp.flag_nv, held_rsp.flag_nv);
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES) fail_run("timeout, run exceeded its cycle budget");
  end

  initial begin
    fpu_req_t r;
    void'($urandom(86));                          // One seed for the whole run
    clk       = 1'b0;
    rst_n     = 1'b0;
    start     = 1'b0;
    req       = '0;
    held_rsp  = '0;                               // Reset value of rsp
    n_checked = 0;
    cycle_cnt = 0;
    repeat (5) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;

    // Every pairing of special operands through min/max and compare
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 8; j++) begin
        r           = '0;
        r.operand_a = specials[i];
        r.operand_b = specials[j];
        r.op        = ((i * 8 + j) % 2 == 0) ? FP_MIN : FP_MAX;
        drive_req(r, 1'b1);                       // Back to back
        r.op        = FP_CMP;
        r.funct3    = cmp_codes[(i * 8 + j) % 3];
        drive_req(r, 1'b1);
      end
    end
    // Sign injection, class and moves on each special value
    for (int i = 0; i < 8; i++) begin
      r             = '0;
      r.operand_a   = specials[i];
      r.operand_b   = specials[7 - i];
      r.int_operand = specials[i] ^ 32'h0000_FFFF;
      r.op          = legal_ops[i % 3];
      drive_req(r, 1'b1);
      r.op          = FP_CLASS;
      drive_req(r, 1'b1);
      r.op          = (i % 2 == 0) ? FP_MV_XW : FP_MV_WX;
      drive_req(r, 1'b1);
    end

    // Random requests with idles and the odd illegal op
    for (int n = 0; n < 2000; n++) begin
      if ($urandom % 10 == 0) idle_cycle();
      if ($urandom % 64 == 0) begin
        r    = random_req();
        r.op = fpu_op_e'(illegal_code());
        drive_req(r, 1'b1);                       // Must give no done
      end
      drive_req(random_req(), 1'b1);
    end

    // Latency is one cycle so a short drain is enough
    repeat (3) idle_cycle();
    if (exp_q.size() != 0) begin
      fail_run($sformatf("%0d expected results never came back", exp_q.size()));
    end else begin
      $display("%0d results checked", n_checked);
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+src
src/fpu_pkg.sv
src/fp_classify.sv
src/fp_compare.sv
src/fpu_result_sel.sv
src/fpu.sv
bench/fpu_chk.sv
bench/fpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the FPU testbench

SRCS := $(shell grep -v '^+' files.f) $(wildcard src/*.svh)

.PHONY: run clean

run: obj_dir/Vfpu_tb
	@out=$$(./obj_dir/Vfpu_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

# Rebuilt only when a source or the file list changes
obj_dir/Vfpu_tb: files.f $(SRCS)
	verilator --binary --timing --assert --top-module fpu_tb -f files.f

clean:
	rm -rf obj_dir
